// File: hw/icache_geom_pkg.sv
// Geometry and replacement constants of the two-way instruction cache.
// The sizes are fixed, and tag_w + index_w + offset_w must equal the
// address width in icache_bus_pkg.
`default_nettype none

package icache_geom_pkg;

    // 64 sets, each set holds one word per way
    localparam int unsigned num_sets = 64;

    // set index taken from address bits 8..3
    localparam int unsigned index_w = 6;

    // tag is address bits 63..9
    localparam int unsigned tag_w = 55;

    // low bits ignored, so every line holds a single word
    localparam int unsigned offset_w = 3;

    // saturating age counters per way and per set
    localparam int unsigned age_w = 3;
    localparam int unsigned age_max = 7;

endpackage

`default_nettype wire

// File: hw/icache_bus_pkg.sv
// Fetch and memory bus widths, plus the fetch address view.
// The address fields take their widths from icache_geom_pkg, and the
// struct inside the union must fill addr_w exactly.
`default_nettype none

package icache_bus_pkg;

    // byte address on both the fetch and the memory side
    localparam int unsigned addr_w = 64;

    // one instruction word
    localparam int unsigned inst_w = 32;

    // same 64 bits, read flat for the memory bus or split for the lookup
    typedef union packed {
        logic [addr_w-1:0] flat;
        struct packed {
            logic [icache_geom_pkg::tag_w-1:0]    tag;
            logic [icache_geom_pkg::index_w-1:0]  index;
            logic [icache_geom_pkg::offset_w-1:0] offset;
        } f;
    } fetch_addr_u;

endpackage

`default_nettype wire

// File: hw/icache_tag_ram.sv
// Tag array of one cache way, with a valid bit per set.
// The read is registered, so o_tag and o_valid follow i_index one edge later.
// Reset clears the valid bits only. Tags stay unknown until written.
`default_nettype none

module icache_tag_ram (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [icache_geom_pkg::index_w-1:0] i_index,
    input  logic                                i_we,
    input  logic [icache_geom_pkg::tag_w-1:0]   i_tag,
    output logic [icache_geom_pkg::tag_w-1:0]   o_tag,
    output logic                                o_valid
);

    logic [icache_geom_pkg::tag_w-1:0] tags [icache_geom_pkg::num_sets];
    logic [icache_geom_pkg::num_sets-1:0] valid;

    // valid bits and their read port
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid <= '0;
            o_valid <= 1'b0;
        end else begin
            if (i_we) begin
                valid[i_index] <= 1'b1;
            end
            o_valid <= valid[i_index];
        end
    end

    // tag storage, read returns the old value on a write edge
    always_ff @(posedge clk) begin
        if (i_we) begin
            tags[i_index] <= i_tag;
        end
        o_tag <= tags[i_index];
    end

endmodule

`default_nettype wire

// File: hw/icache_data_ram.sv
// Instruction word array of one cache way.
// Registered read with one cycle of latency and no reset.
`default_nettype none

module icache_data_ram (
    input  logic                                clk,
    input  logic [icache_geom_pkg::index_w-1:0] i_index,
    input  logic                                i_we,
    input  logic [icache_bus_pkg::inst_w-1:0]   i_data,
    output logic [icache_bus_pkg::inst_w-1:0]   o_data
);

    logic [icache_bus_pkg::inst_w-1:0] words [icache_geom_pkg::num_sets];

    always_ff @(posedge clk) begin
        if (i_we) begin
            words[i_index] <= i_data;
        end
        o_data <= words[i_index];
    end

    // a refill must land in a known set
    a_we_index_known: assert property (
        @(posedge clk) i_we |-> !$isunknown(i_index)
    ) else $error("icache_data_ram: write with unknown index %h", i_index);

endmodule

`default_nettype wire

// File: hw/icache_age_lru.sv
// Age-based victim choice for the two ways of every set.
// Each touch ages all sets, saturating at age_max, then clears the touched
// way of the indexed set. The victim is combinational from the counters and
// expects i_valid0/i_valid1 to belong to the set selected by i_index.
`default_nettype none

module icache_age_lru (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [icache_geom_pkg::index_w-1:0] i_index,
    input  logic                                i_touch,
    input  logic                                i_touch_way,
    input  logic                                i_valid0,
    input  logic                                i_valid1,
    output logic                                o_victim
);

    logic [icache_geom_pkg::age_w-1:0] age0 [icache_geom_pkg::num_sets];
    logic [icache_geom_pkg::age_w-1:0] age1 [icache_geom_pkg::num_sets];
    logic [icache_geom_pkg::age_w-1:0] cur0;
    logic [icache_geom_pkg::age_w-1:0] cur1;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < icache_geom_pkg::num_sets; s++) begin
                age0[s] <= '0;
                age1[s] <= '0;
            end
        end else if (i_touch) begin
            // age every set
            for (int s = 0; s < icache_geom_pkg::num_sets; s++) begin
                if (age0[s] != icache_geom_pkg::age_max) begin
                    age0[s] <= age0[s] + 1'b1;
                end
                if (age1[s] != icache_geom_pkg::age_max) begin
                    age1[s] <= age1[s] + 1'b1;
                end
            end
            // later assignment wins, so the touched way ends at zero
            if (i_touch_way) begin
                age1[i_index] <= '0;
            end else begin
                age0[i_index] <= '0;
            end
        end
    end

    assign cur0 = age0[i_index];
    assign cur1 = age1[i_index];

    // empty way first, then the older one, ties to way 0
    always_comb begin
        if (!i_valid0) begin
            o_victim = 1'b0;
        end else if (!i_valid1) begin
            o_victim = 1'b1;
        end else begin
            o_victim = (cur1 > cur0);
        end
    end

endmodule

`default_nettype wire

// File: hw/icache_ctrl.sv
// Lookup and refill controller of the two-way instruction cache.
// One fetch in flight. A hit acks two edges after req is sampled, and a miss
// acks one edge after the memory ack. A new memory req waits for the last
// memory ack to fall. Ack and data hold until the core drops req.
`default_nettype none

module icache_ctrl (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                i_fetch_req,
    input  icache_bus_pkg::fetch_addr_u         i_fetch_addr,
    output logic                                o_fetch_ack,
    output logic [icache_bus_pkg::inst_w-1:0]   o_fetch_data,
    output logic                                o_mem_req,
    output logic [icache_bus_pkg::addr_w-1:0]   o_mem_addr,
    input  logic                                i_mem_ack,
    input  logic [icache_bus_pkg::inst_w-1:0]   i_mem_data,
    output logic [icache_geom_pkg::index_w-1:0] o_index,
    output logic                                o_tag_we0,
    output logic                                o_tag_we1,
    output logic [icache_geom_pkg::tag_w-1:0]   o_wr_tag,
    input  logic [icache_geom_pkg::tag_w-1:0]   i_tag0,
    input  logic                                i_valid0,
    input  logic [icache_geom_pkg::tag_w-1:0]   i_tag1,
    input  logic                                i_valid1,
    output logic                                o_data_we0,
    output logic                                o_data_we1,
    output logic [icache_bus_pkg::inst_w-1:0]   o_wr_data,
    input  logic [icache_bus_pkg::inst_w-1:0]   i_data0,
    input  logic [icache_bus_pkg::inst_w-1:0]   i_data1,
    output logic                                o_touch,
    output logic                                o_touch_way,
    input  logic                                i_victim
);

    // one-hot state flops
    logic s_idle;
    logic s_lookup;
    logic s_compare;
    logic s_refill;
    logic s_fill;
    logic s_respond;

    icache_bus_pkg::fetch_addr_u addr_q;
    logic [icache_bus_pkg::inst_w-1:0] refill_q;
    logic victim_q;
    logic hit0;
    logic hit1;
    logic hit;
    logic mem_done;

    assign hit0 = i_valid0 && (i_tag0 == addr_q.f.tag);
    assign hit1 = i_valid1 && (i_tag1 == addr_q.f.tag);
    assign hit = hit0 || hit1;
    assign mem_done = s_refill && o_mem_req && i_mem_ack;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            s_idle <= 1'b1;
            s_lookup <= 1'b0;
            s_compare <= 1'b0;
            s_refill <= 1'b0;
            s_fill <= 1'b0;
            s_respond <= 1'b0;
            o_fetch_ack <= 1'b0;
            o_mem_req <= 1'b0;
        end else begin
            if (s_idle && i_fetch_req) begin
                s_idle <= 1'b0;
                s_lookup <= 1'b1;
            end
            // RAM read issued from the latched index
            if (s_lookup) begin
                s_lookup <= 1'b0;
                s_compare <= 1'b1;
            end
            if (s_compare) begin
                s_compare <= 1'b0;
                if (hit) begin
                    s_respond <= 1'b1;
                    o_fetch_ack <= 1'b1;
                end else begin
                    s_refill <= 1'b1;
                    o_mem_req <= !i_mem_ack;
                end
            end
            // previous memory ack may still be high
            if (s_refill) begin
                if (mem_done) begin
                    o_mem_req <= 1'b0;
                    s_refill <= 1'b0;
                    s_fill <= 1'b1;
                end else if (!o_mem_req && !i_mem_ack) begin
                    o_mem_req <= 1'b1;
                end
            end
            if (s_fill) begin
                s_fill <= 1'b0;
                s_respond <= 1'b1;
                o_fetch_ack <= 1'b1;
            end
            if (s_respond && !i_fetch_req) begin
                s_respond <= 1'b0;
                s_idle <= 1'b1;
                o_fetch_ack <= 1'b0;
            end
        end
    end

    // address, victim and returned word
    always_ff @(posedge clk) begin
        if (s_idle && i_fetch_req) begin
            addr_q <= i_fetch_addr;
        end
        if (s_compare) begin
            victim_q <= i_victim;
        end
        if (mem_done) begin
            refill_q <= i_mem_data;
        end
        if (s_compare && hit) begin
            o_fetch_data <= hit1 ? i_data1 : i_data0;
        end else if (s_fill) begin
            o_fetch_data <= refill_q;
        end
    end

    assign o_mem_addr = addr_q.flat;
    assign o_index = addr_q.f.index;
    assign o_wr_tag = addr_q.f.tag;
    assign o_wr_data = refill_q;

    // fill writes the victim way only
    assign o_tag_we0 = s_fill && !victim_q;
    assign o_tag_we1 = s_fill && victim_q;
    assign o_data_we0 = s_fill && !victim_q;
    assign o_data_we1 = s_fill && victim_q;

    // ages update on the edge where ack rises
    assign o_touch = (s_compare && hit) || s_fill;
    assign o_touch_way = s_fill ? victim_q : hit1;

    a_state_onehot: assert property (
        @(posedge clk) disable iff (!rst)
        $onehot({s_idle, s_lookup, s_compare, s_refill, s_fill, s_respond})
    ) else $error("icache_ctrl: state not one-hot");

    // both tag RAMs must never hold the same valid tag for one set
    a_single_hit: assert property (
        @(posedge clk) disable iff (!rst) s_compare |-> !(hit0 && hit1)
    ) else $error("icache_ctrl: tag %h hits both ways", addr_q.f.tag);

    a_req_ack_apart: assert property (
        @(posedge clk) disable iff (!rst) !(o_mem_req && o_fetch_ack)
    ) else $error("icache_ctrl: o_mem_req high with o_fetch_ack");

endmodule

`default_nettype wire

// File: hw/icache_top.sv
// Two-way set-associative instruction cache, one word per line.
// Fetch and memory sides both use a four-phase req/ack handshake.
// Address bits 2..0 are ignored, so addresses differing only there alias.
`default_nettype none

module icache_top (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              i_fetch_req,
    input  logic [icache_bus_pkg::addr_w-1:0] i_fetch_addr,
    output logic                              o_fetch_ack,
    output logic [icache_bus_pkg::inst_w-1:0] o_fetch_data,
    output logic                              o_mem_req,
    output logic [icache_bus_pkg::addr_w-1:0] o_mem_addr,
    input  logic                              i_mem_ack,
    input  logic [icache_bus_pkg::inst_w-1:0] i_mem_data
);

    icache_bus_pkg::fetch_addr_u fetch_addr;
    logic [icache_geom_pkg::index_w-1:0] index;
    logic tag_we0;
    logic tag_we1;
    logic [icache_geom_pkg::tag_w-1:0] wr_tag;
    logic [icache_geom_pkg::tag_w-1:0] tag0;
    logic [icache_geom_pkg::tag_w-1:0] tag1;
    logic valid0;
    logic valid1;
    logic data_we0;
    logic data_we1;
    logic [icache_bus_pkg::inst_w-1:0] wr_data;
    logic [icache_bus_pkg::inst_w-1:0] data0;
    logic [icache_bus_pkg::inst_w-1:0] data1;
    logic touch;
    logic touch_way;
    logic victim;

    assign fetch_addr.flat = i_fetch_addr;

    icache_ctrl u_ctrl (
        .clk, .rst, .i_fetch_req, .i_fetch_addr(fetch_addr), .o_fetch_ack, .o_fetch_data,
        .o_mem_req, .o_mem_addr, .i_mem_ack, .i_mem_data,
        .o_index(index), .o_tag_we0(tag_we0), .o_tag_we1(tag_we1), .o_wr_tag(wr_tag),
        .i_tag0(tag0), .i_valid0(valid0), .i_tag1(tag1), .i_valid1(valid1),
        .o_data_we0(data_we0), .o_data_we1(data_we1), .o_wr_data(wr_data),
        .i_data0(data0), .i_data1(data1),
        .o_touch(touch), .o_touch_way(touch_way), .i_victim(victim)
    );

    icache_tag_ram u_tag0 (
        .clk, .rst, .i_index(index), .i_we(tag_we0), .i_tag(wr_tag),
        .o_tag(tag0), .o_valid(valid0)
    );

    icache_tag_ram u_tag1 (
        .clk, .rst, .i_index(index), .i_we(tag_we1), .i_tag(wr_tag),
        .o_tag(tag1), .o_valid(valid1)
    );

    icache_data_ram u_data0 (
        .clk, .i_index(index), .i_we(data_we0), .i_data(wr_data), .o_data(data0)
    );

    icache_data_ram u_data1 (
        .clk, .i_index(index), .i_we(data_we1), .i_data(wr_data), .o_data(data1)
    );

    // valid bits come from the registered tag read of the same set
    icache_age_lru u_age (
        .clk, .rst, .i_index(index), .i_touch(touch), .i_touch_way(touch_way),
        .i_valid0(valid0), .i_valid1(valid1), .o_victim(victim)
    );

endmodule

`default_nettype wire

// File: bench/icache_mem_model.sv
// Memory responder for the cache testbench, four-phase req/ack.
// Ack comes 1 to 4 cycles after req is seen, from an xorshift sequence.
// The word is the address's low 32 bits with bits 31..16 inverted.
`default_nettype none

module icache_mem_model (
    input  logic                              clk,
    input  logic                              i_req,
    input  logic [icache_bus_pkg::addr_w-1:0] i_addr,
    output logic                              o_ack,
    output logic [icache_bus_pkg::inst_w-1:0] o_data
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [31:0] rand_state;
    int delay;

    function automatic logic [31:0] next_rand(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    initial begin
        rand_state = 32'd33006;
        o_ack = 1'b0;
        o_data = '0;
        forever begin
            @(posedge clk);
            #10;
            if (i_req && !o_ack) begin
                rand_state = next_rand(rand_state);
                delay = int'(rand_state % 4) + 1;
                repeat (delay) begin
                    @(posedge clk);
                    #10;
                end
                o_ack = 1'b1;
                o_data = {~i_addr[31:16], i_addr[15:0]};
                // hold until the cache drops req
                do begin
                    @(posedge clk);
                    #10;
                end while (i_req);
                o_ack = 1'b0;
                o_data = '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: bench/tb_icache.sv
// Testbench for the two-way instruction cache.
// Only offset zero is fetched, since bits 2..0 alias within a line.
// A reference model of valid bits, tags and ages predicts each hit and miss.
`default_nettype none

module tb_icache;
    timeunit 1ns;
    timeprecision 100ps;

    logic clk;
    logic rst;
    logic fetch_req;
    logic [63:0] fetch_addr;
    logic fetch_ack;
    logic [31:0] fetch_data;
    logic mem_req;
    logic [63:0] mem_addr;
    logic mem_ack;
    logic [31:0] mem_data;

    // stimulus table with one row per fetch
    logic [63:0] step_addr [$];
    int step_hold [$];
    bit step_reset [$];
    bit step_hit [$];

    // reference copy of the cache state
    bit ref_valid [2][64];
    logic [54:0] ref_tag [2][64];
    logic [31:0] ref_word [2][64];
    int ref_age [2][64];

    int cycles = 0;
    int cycle_limit = 0;
    int mem_req_rises = 0;
    logic mem_req_prev = 1'b0;

    icache_top dut0 (
        .clk, .rst, .i_fetch_req(fetch_req), .i_fetch_addr(fetch_addr),
        .o_fetch_ack(fetch_ack), .o_fetch_data(fetch_data), .o_mem_req(mem_req),
        .o_mem_addr(mem_addr), .i_mem_ack(mem_ack), .i_mem_data(mem_data)
    );

    icache_mem_model u_mem (
        .clk, .i_req(mem_req), .i_addr(mem_addr), .o_ack(mem_ack), .o_data(mem_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_run();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    // memory req edges and the run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (mem_req && !mem_req_prev) begin
            mem_req_rises <= mem_req_rises + 1;
        end
        mem_req_prev <= mem_req;
        assert (cycle_limit == 0 || cycles < cycle_limit) else begin
            $display("Timeout: the cache did not finish within %0d cycles", cycle_limit);
            stop_run();
        end
    end

    function automatic logic [63:0] make_addr(input logic [54:0] tag, input logic [5:0] idx);
        return {tag, idx, 3'b000};
    endfunction

    function automatic logic [31:0] mem_word(input logic [63:0] addr);
        return {~addr[31:16], addr[15:0]};
    endfunction

    task automatic add_step(input logic [54:0] tag, input logic [5:0] idx, input int hold,
                            input bit do_reset, input bit hit);
        step_addr.push_back(make_addr(tag, idx));
        step_hold.push_back(hold);
        step_reset.push_back(do_reset);
        step_hit.push_back(hit);
    endtask

    task automatic build_table();
        logic [54:0] ta;
        logic [54:0] tb;
        logic [54:0] tc;
        logic [54:0] td;
        ta = 55'h0_0000_0000_1234;
        tb = 55'h5_A5A5_0000_0042;
        tc = 55'h7F_FFFF_FFFF_FFF0;
        td = 55'h0_0001_0000_0000;
        // set 5 fills, hits, then a third tag evicts the older way
        add_step(ta, 6'd5, 0, 0, 0);
        add_step(ta, 6'd5, 0, 0, 1);
        add_step(tb, 6'd5, 0, 0, 0);
        add_step(ta, 6'd5, 0, 0, 1);
        add_step(tb, 6'd5, 0, 0, 1);
        add_step(tc, 6'd5, 0, 0, 0);
        add_step(tb, 6'd5, 0, 0, 1);
        add_step(ta, 6'd5, 0, 0, 0);
        // other sets, long holds, then set 5 ages saturate into a tie
        add_step(ta, 6'd9, 5, 0, 0);
        add_step(ta, 6'd9, 3, 0, 1);
        add_step(tb, 6'd63, 0, 0, 0);
        add_step(tc, 6'd0, 0, 0, 0);
        add_step(td, 6'd63, 0, 0, 0);
        add_step(tb, 6'd9, 0, 0, 0);
        add_step(tc, 6'd9, 0, 0, 0);
        add_step(ta, 6'd9, 0, 0, 0);
        add_step(tc, 6'd5, 0, 0, 0);
        add_step(tb, 6'd5, 2, 0, 1);
        add_step(ta, 6'd5, 0, 0, 0);
        // second reset drops every line
        add_step(ta, 6'd5, 0, 1, 0);
        add_step(tb, 6'd5, 0, 0, 0);
        add_step(ta, 6'd5, 4, 0, 1);
        add_step(tb, 6'd5, 0, 0, 1);
        add_step(tc, 6'd5, 0, 0, 0);
        add_step(tb, 6'd5, 0, 0, 1);
        add_step(ta, 6'd5, 0, 0, 0);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #10;
        rst = 1'b0;
        repeat (8) @(posedge clk);
        #10;
        rst = 1'b1;
        for (int w = 0; w < 2; w++) begin
            for (int s = 0; s < 64; s++) begin
                ref_valid[w][s] = 1'b0;
                ref_age[w][s] = 0;
            end
        end
    endtask

    // hit or fill by the age rule, then age every counter
    task automatic ref_access(input logic [63:0] addr, output bit hit, output logic [31:0] word);
        logic [54:0] tag;
        int idx;
        int way;
        tag = addr[63:9];
        idx = addr[8:3];
        hit = 1'b0;
        way = 0;
        for (int w = 0; w < 2; w++) begin
            if (ref_valid[w][idx] && ref_tag[w][idx] == tag) begin
                hit = 1'b1;
                way = w;
            end
        end
        if (!hit) begin
            if (!ref_valid[0][idx]) begin
                way = 0;
            end else if (!ref_valid[1][idx]) begin
                way = 1;
            end else begin
                way = (ref_age[1][idx] > ref_age[0][idx]) ? 1 : 0;
            end
            ref_valid[way][idx] = 1'b1;
            ref_tag[way][idx] = tag;
            ref_word[way][idx] = mem_word(addr);
        end
        word = ref_word[way][idx];
        for (int w = 0; w < 2; w++) begin
            for (int s = 0; s < 64; s++) begin
                if (ref_age[w][s] < 7) begin
                    ref_age[w][s]++;
                end
            end
        end
        ref_age[way][idx] = 0;
    endtask

    task automatic run_fetch(input int n);
        logic [63:0] addr;
        logic [31:0] exp_word;
        bit ref_hit;
        int edges;
        int req_edge;
        int ack_edge;
        int rises_before;
        addr = step_addr[n];
        ref_access(addr, ref_hit, exp_word);
        assert (ref_hit == step_hit[n]) else begin
            $display("Table row %0d disagrees with the reference age rule", n);
            stop_run();
        end
        rises_before = mem_req_rises;
        edges = 0;
        req_edge = -1;
        ack_edge = -1;
        @(posedge clk);
        #10;
        fetch_addr = addr;
        fetch_req = 1'b1;
        do begin
            @(posedge clk);
            edges++;
            @(negedge clk);
            if (mem_req && req_edge < 0) begin
                req_edge = edges;
                assert (mem_addr == addr) else begin
                    $display("Error: o_mem_addr = %h, expected %h", mem_addr, addr);
                    stop_run();
                end
            end
            if (mem_ack && ack_edge < 0) begin
                ack_edge = edges;
            end
        end while (!fetch_ack);
        assert (fetch_data == exp_word) else begin
            $display("Error: o_fetch_data = %h, expected %h (row %0d)", fetch_data, exp_word, n);
            stop_run();
        end
        // a hit acks on edge three and a miss two edges after the memory ack
        if (step_hit[n]) begin
            assert (edges == 3 && req_edge < 0) else begin
                $display("Error: o_fetch_ack after %h edges, expected %h (row %0d)", edges, 3, n);
                stop_run();
            end
        end else begin
            assert (req_edge == 3 && edges - ack_edge == 2) else begin
                $display("Error: o_mem_req edge %h, o_fetch_ack lag %h, expected %h and %h",
                         req_edge, edges - ack_edge, 3, 2);
                stop_run();
            end
        end
        repeat (step_hold[n]) begin
            @(negedge clk);
            assert (fetch_ack && fetch_data == exp_word) else begin
                $display("Error: o_fetch_ack = %h, o_fetch_data = %h, expected 1 and %h",
                         fetch_ack, fetch_data, exp_word);
                stop_run();
            end
        end
        @(posedge clk);
        #10;
        fetch_req = 1'b0;
        do begin
            @(negedge clk);
        end while (fetch_ack);
        assert (mem_req_rises - rises_before == (step_hit[n] ? 0 : 1)) else begin
            $display("Error: o_mem_req rose %h times in row %0d", mem_req_rises - rises_before, n);
            stop_run();
        end
    endtask

    initial begin
        rst = 1'b0;
        fetch_req = 1'b0;
        fetch_addr = '0;
        build_table();
        cycle_limit = 60 * step_addr.size();
        apply_reset();
        for (int n = 0; n < step_addr.size(); n++) begin
            if (step_reset[n]) begin
                apply_reset();
            end
            run_fetch(n);
        end
        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
hw/icache_geom_pkg.sv
hw/icache_bus_pkg.sv
hw/icache_tag_ram.sv
hw/icache_data_ram.sv
hw/icache_age_lru.sv
hw/icache_ctrl.sv
hw/icache_top.sv
bench/icache_mem_model.sv
bench/tb_icache.sv

// File: Bender.yml
package:
  name: icache

sources:
  - files:
      - hw/icache_geom_pkg.sv
      - hw/icache_bus_pkg.sv
      - hw/icache_tag_ram.sv
      - hw/icache_data_ram.sv
      - hw/icache_age_lru.sv
      - hw/icache_ctrl.sv
      - hw/icache_top.sv
  - target: test
    files:
      - bench/icache_mem_model.sv
      - bench/tb_icache.sv
